// ==== verilog/prf_pkg.sv ====
// physical register file definitions
`default_nettype none

package prf_pkg;

    // ------------------------------------------------------------
    // default sizes

    localparam int DEF_PR_COUNT   = 64;
    localparam int DEF_BANK_COUNT = 4;
    localparam int DEF_RR_COUNT   = 6;
    localparam int DEF_WR_COUNT   = 4;

    // one register value
    typedef logic [31:0] prf_word_t;

    // ------------------------------------------------------------
    // register number split, bank count is a power of two

    function automatic int unsigned bank_of(input int unsigned pr, input int unsigned bank_count);
        return pr % bank_count;
    endfunction

    function automatic int unsigned upper_of(input int unsigned pr, input int unsigned bank_count);
        return pr / bank_count;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/bank_arbiter.sv ====
// rotating priority bank arbiter
`timescale 1ns/1ns
`default_nettype none

module bank_arbiter import prf_pkg::*; #(
    parameter int  N         = DEF_RR_COUNT,
    parameter type payload_t = prf_word_t
) (
    input  logic           CLK,
    input  logic           nRST,
    input  logic [N-1:0]   req,
    input  payload_t       payload [N],
    output logic [N-1:0]   grant,
    output payload_t       sel_payload,
    output logic           any_grant
);

    localparam int PW = $bits(payload_t);

    logic [N-1:0]  mask;
    logic [N-1:0]  next_mask;
    logic [N-1:0]  masked_req;
    logic [N-1:0]  pick_vec;
    logic [PW-1:0] payload_or;

    // one-hot of the highest set bit
    function automatic logic [N-1:0] highest(input logic [N-1:0] vec);
        logic [N-1:0] one_hot;
        one_hot = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (vec[i] && (one_hot == '0)) begin
                one_hot[i] = 1'b1;
            end
        end
        return one_hot;
    endfunction

    // masked requests win when any are left in this round
    assign masked_req = req & mask;
    assign pick_vec   = (|masked_req) ? masked_req : req;
    assign grant      = highest(pick_vec);
    assign any_grant  = |req;

    // one-hot payload mux
    always_comb begin
        logic [PW-1:0] entry_bits;
        payload_or = '0;
        for (int i = 0; i < N; i++) begin
            entry_bits = payload[i];
            payload_or = payload_or | (entry_bits & {PW{grant[i]}});
        end
    end

    assign sel_payload = payload_or;

    // after a grant to r only requesters below r stay in the round
    always_comb begin
        next_mask = mask;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                next_mask = (N'(1) << i) - N'(1);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mask <= '0;
        end else begin
            mask <= next_mask;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wb_hold.sv ====
// writeback hold buffer
`timescale 1ns/1ns
`default_nettype none

module wb_hold import prf_pkg::*; #(
    parameter int WR_COUNT   = DEF_WR_COUNT,
    parameter int PR_COUNT   = DEF_PR_COUNT,
    localparam int PR_W      = $clog2(PR_COUNT)
) (
    input  logic                               CLK,
    input  logic                               nRST,
    input  logic      [WR_COUNT-1:0]           wb_valid,
    input  logic      [WR_COUNT-1:0][PR_W-1:0] wb_pr,
    input  prf_word_t [WR_COUNT-1:0]           wb_data,
    input  logic      [WR_COUNT-1:0]           grant,
    output logic      [WR_COUNT-1:0]           req_valid,
    output logic      [WR_COUNT-1:0][PR_W-1:0] req_pr,
    output prf_word_t [WR_COUNT-1:0]           req_data,
    output logic      [WR_COUNT-1:0]           wb_ready
);

    logic      [WR_COUNT-1:0]           held_valid;
    logic      [WR_COUNT-1:0][PR_W-1:0] held_pr;
    prf_word_t [WR_COUNT-1:0]           held_data;

    // ------------------------------------------------------------
    // presented write, held entry first

    always_comb begin
        for (int w = 0; w < WR_COUNT; w++) begin
            req_valid[w] = held_valid[w] | wb_valid[w];
            req_pr[w]    = held_valid[w] ? held_pr[w] : wb_pr[w];
            req_data[w]  = held_valid[w] ? held_data[w] : wb_data[w];
        end
    end

    // stall only while both a held and a new write exist
    assign wb_ready = ~(held_valid & wb_valid);

    // ------------------------------------------------------------
    // capture what lost arbitration

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
        end else begin
            held_valid <= req_valid & ~grant;
        end
    end

    always_ff @(posedge CLK) begin
        for (int w = 0; w < WR_COUNT; w++) begin
            if (req_valid[w] && !grant[w]) begin
                held_pr[w]   <= req_pr[w];
                held_data[w] <= req_data[w];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/read_port_select.sv ====
// register read port selection
`timescale 1ns/1ns
`default_nettype none

module read_port_select import prf_pkg::*; #(
    parameter int  PR_COUNT   = DEF_PR_COUNT,
    parameter int  BANK_COUNT = DEF_BANK_COUNT,
    parameter int  RR_COUNT   = DEF_RR_COUNT,
    localparam int PR_W       = $clog2(PR_COUNT),
    localparam int ROW_W      = PR_W - $clog2(BANK_COUNT)
) (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic [RR_COUNT-1:0]                    rd_req_valid,
    input  logic [RR_COUNT-1:0][PR_W-1:0]          rd_req_pr,
    output logic [RR_COUNT-1:0]                    rd_ack,
    output logic [RR_COUNT-1:0]                    rd_port,
    output logic [BANK_COUNT-1:0][1:0][ROW_W-1:0]  rd_row
);

    typedef logic [ROW_W-1:0] row_t;

    logic [BANK_COUNT-1:0][RR_COUNT-1:0] req_by_bank;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port1_req;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port0_grant;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port1_grant;
    logic [BANK_COUNT-1:0]               port0_any;
    logic [BANK_COUNT-1:0]               port1_any;
    row_t                                row_by_rr [RR_COUNT];
    row_t                                port0_row [BANK_COUNT];
    row_t                                port1_row [BANK_COUNT];

    // ------------------------------------------------------------
    // route requests to banks

    always_comb begin
        req_by_bank = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            row_by_rr[r] = ROW_W'(upper_of(rd_req_pr[r], BANK_COUNT));
            for (int b = 0; b < BANK_COUNT; b++) begin
                req_by_bank[b][r] = rd_req_valid[r] &&
                    (bank_of(rd_req_pr[r], BANK_COUNT) == b);
            end
        end
    end

    // ------------------------------------------------------------
    // two ports per bank, port 1 sees what port 0 left

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        assign port1_req[b] = req_by_bank[b] & ~port0_grant[b];

        bank_arbiter #(
            .N         (RR_COUNT),
            .payload_t (row_t)
        ) port0_arb_i (
            .CLK         (CLK),
            .nRST        (nRST),
            .req         (req_by_bank[b]),
            .payload     (row_by_rr),
            .grant       (port0_grant[b]),
            .sel_payload (port0_row[b]),
            .any_grant   (port0_any[b])
        );

        bank_arbiter #(
            .N         (RR_COUNT),
            .payload_t (row_t)
        ) port1_arb_i (
            .CLK         (CLK),
            .nRST        (nRST),
            .req         (port1_req[b]),
            .payload     (row_by_rr),
            .grant       (port1_grant[b]),
            .sel_payload (port1_row[b]),
            .any_grant   (port1_any[b])
        );
    end

    // a requester maps to one bank, so OR over banks is safe
    always_comb begin
        rd_ack  = '0;
        rd_port = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            rd_ack  = rd_ack | port0_grant[b] | port1_grant[b];
            rd_port = rd_port | port1_grant[b];
        end
    end

    // read rows, data follows next cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_row <= '0;
        end else begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (port0_any[b]) begin
                    rd_row[b][0] <= port0_row[b];
                end
                if (port1_any[b]) begin
                    rd_row[b][1] <= port1_row[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wb_select.sv ====
// writeback selection and bus
`timescale 1ns/1ns
`default_nettype none

module wb_select import prf_pkg::*; #(
    parameter int  PR_COUNT   = DEF_PR_COUNT,
    parameter int  BANK_COUNT = DEF_BANK_COUNT,
    parameter int  WR_COUNT   = DEF_WR_COUNT,
    localparam int PR_W       = $clog2(PR_COUNT),
    localparam int ROW_W      = PR_W - $clog2(BANK_COUNT)
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic      [WR_COUNT-1:0]              req_valid,
    input  logic      [WR_COUNT-1:0][PR_W-1:0]    req_pr,
    input  prf_word_t [WR_COUNT-1:0]              req_data,
    output logic      [WR_COUNT-1:0]              grant,
    output logic      [BANK_COUNT-1:0]            wb_bus_valid,
    output logic      [BANK_COUNT-1:0][ROW_W-1:0] wb_bus_upper_pr,
    output prf_word_t [BANK_COUNT-1:0]            wb_bus_data
);

    // row and word travel together through the mux
    typedef struct packed {
        logic [ROW_W-1:0] row;
        prf_word_t        data;
    } wb_entry_t;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0] req_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] grant_by_bank;
    logic [BANK_COUNT-1:0]               bank_any;
    wb_entry_t                           entry_by_wr [WR_COUNT];
    wb_entry_t                           bank_entry [BANK_COUNT];

    // ------------------------------------------------------------
    // route presented writes to banks

    always_comb begin
        req_by_bank = '0;
        for (int w = 0; w < WR_COUNT; w++) begin
            entry_by_wr[w].row  = ROW_W'(upper_of(req_pr[w], BANK_COUNT));
            entry_by_wr[w].data = req_data[w];
            for (int b = 0; b < BANK_COUNT; b++) begin
                req_by_bank[b][w] = req_valid[w] &&
                    (bank_of(req_pr[w], BANK_COUNT) == b);
            end
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        bank_arbiter #(
            .N         (WR_COUNT),
            .payload_t (wb_entry_t)
        ) wb_arb_i (
            .CLK         (CLK),
            .nRST        (nRST),
            .req         (req_by_bank[b]),
            .payload     (entry_by_wr),
            .grant       (grant_by_bank[b]),
            .sel_payload (bank_entry[b]),
            .any_grant   (bank_any[b])
        );
    end

    always_comb begin
        grant = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            grant = grant | grant_by_bank[b];
        end
    end

    // ------------------------------------------------------------
    // bus stage, one cycle ahead of the array write

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_bus_valid <= '0;
        end else begin
            wb_bus_valid <= bank_any;
        end
    end

    always_ff @(posedge CLK) begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            wb_bus_upper_pr[b] <= bank_entry[b].row;
            wb_bus_data[b]     <= bank_entry[b].data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_bank_array.sv ====
// banked register storage
`timescale 1ns/1ns
`default_nettype none

module reg_bank_array import prf_pkg::*; #(
    parameter int  PR_COUNT   = DEF_PR_COUNT,
    parameter int  BANK_COUNT = DEF_BANK_COUNT,
    localparam int ROWS       = PR_COUNT / BANK_COUNT,
    localparam int ROW_W      = $clog2(PR_COUNT) - $clog2(BANK_COUNT)
) (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic      [BANK_COUNT-1:0]                wb_bus_valid,
    input  logic      [BANK_COUNT-1:0][ROW_W-1:0]     wb_bus_upper_pr,
    input  prf_word_t [BANK_COUNT-1:0]                wb_bus_data,
    input  logic      [BANK_COUNT-1:0][1:0][ROW_W-1:0] rd_row,
    output prf_word_t [BANK_COUNT-1:0][1:0]           rd_data
);

    prf_word_t [BANK_COUNT-1:0][ROWS-1:0] mem;

    // one write per bank, taken at the end of the bus cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem <= '0;
        end else begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb_bus_valid[b]) begin
                    mem[b][wb_bus_upper_pr[b]] <= wb_bus_data[b];
                end
            end
        end
    end

    // both ports read from the registered rows
    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            rd_data[b][0] = mem[b][rd_row[b][0]];
            rd_data[b][1] = mem[b][rd_row[b][1]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/prf_top.sv ====
// banked physical register file
`timescale 1ns/1ns
`default_nettype none

module prf_top import prf_pkg::*; #(
    parameter int  PR_COUNT   = DEF_PR_COUNT,
    parameter int  BANK_COUNT = DEF_BANK_COUNT,
    parameter int  RR_COUNT   = DEF_RR_COUNT,
    parameter int  WR_COUNT   = DEF_WR_COUNT,
    localparam int PR_W       = $clog2(PR_COUNT),
    localparam int ROW_W      = PR_W - $clog2(BANK_COUNT)
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    // read requesters
    input  logic      [RR_COUNT-1:0]              rd_req_valid,
    input  logic      [RR_COUNT-1:0][PR_W-1:0]    rd_req_pr,
    output logic      [RR_COUNT-1:0]              rd_ack,
    output logic      [RR_COUNT-1:0]              rd_port,
    output prf_word_t [BANK_COUNT-1:0][1:0]       rd_data,
    // write requesters
    input  logic      [WR_COUNT-1:0]              wb_valid,
    input  logic      [WR_COUNT-1:0][PR_W-1:0]    wb_pr,
    input  prf_word_t [WR_COUNT-1:0]              wb_data,
    output logic      [WR_COUNT-1:0]              wb_ready,
    // writeback bus
    output logic      [BANK_COUNT-1:0]            wb_bus_valid,
    output logic      [BANK_COUNT-1:0][ROW_W-1:0] wb_bus_upper_pr,
    output prf_word_t [BANK_COUNT-1:0]            wb_bus_data
);

    logic      [WR_COUNT-1:0]                  req_valid;
    logic      [WR_COUNT-1:0][PR_W-1:0]        req_pr;
    prf_word_t [WR_COUNT-1:0]                  req_data;
    logic      [WR_COUNT-1:0]                  grant;
    logic      [BANK_COUNT-1:0][1:0][ROW_W-1:0] rd_row;

    // ------------------------------------------------------------
    // read side

    read_port_select #(
        .PR_COUNT   (PR_COUNT),
        .BANK_COUNT (BANK_COUNT),
        .RR_COUNT   (RR_COUNT)
    ) read_sel_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .rd_req_valid (rd_req_valid),
        .rd_req_pr    (rd_req_pr),
        .rd_ack       (rd_ack),
        .rd_port      (rd_port),
        .rd_row       (rd_row)
    );

    // ------------------------------------------------------------
    // write side

    wb_hold #(
        .WR_COUNT (WR_COUNT),
        .PR_COUNT (PR_COUNT)
    ) wb_hold_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .wb_valid  (wb_valid),
        .wb_pr     (wb_pr),
        .wb_data   (wb_data),
        .grant     (grant),
        .req_valid (req_valid),
        .req_pr    (req_pr),
        .req_data  (req_data),
        .wb_ready  (wb_ready)
    );

    wb_select #(
        .PR_COUNT   (PR_COUNT),
        .BANK_COUNT (BANK_COUNT),
        .WR_COUNT   (WR_COUNT)
    ) wb_sel_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .req_valid       (req_valid),
        .req_pr          (req_pr),
        .req_data        (req_data),
        .grant           (grant),
        .wb_bus_valid    (wb_bus_valid),
        .wb_bus_upper_pr (wb_bus_upper_pr),
        .wb_bus_data     (wb_bus_data)
    );

    // storage
    reg_bank_array #(
        .PR_COUNT   (PR_COUNT),
        .BANK_COUNT (BANK_COUNT)
    ) array_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .wb_bus_valid    (wb_bus_valid),
        .wb_bus_upper_pr (wb_bus_upper_pr),
        .wb_bus_data     (wb_bus_data),
        .rd_row          (rd_row),
        .rd_data         (rd_data)
    );

endmodule

`default_nettype wire

// ==== test/prf_properties.sv ====
// register file arbitration properties
`timescale 1ns/1ns
`default_nettype none

module prf_properties import prf_pkg::*; #(
    parameter int  PR_COUNT   = DEF_PR_COUNT,
    parameter int  BANK_COUNT = DEF_BANK_COUNT,
    parameter int  RR_COUNT   = DEF_RR_COUNT,
    parameter int  WR_COUNT   = DEF_WR_COUNT,
    localparam int PR_W       = $clog2(PR_COUNT)
) (
    input logic                          CLK,
    input logic                          nRST,
    input logic [RR_COUNT-1:0]           rd_req_valid,
    input logic [RR_COUNT-1:0][PR_W-1:0] rd_req_pr,
    input logic [RR_COUNT-1:0]           rd_ack,
    input logic [WR_COUNT-1:0]           req_valid,
    input logic [WR_COUNT-1:0][PR_W-1:0] req_pr,
    input logic [WR_COUNT-1:0]           grant,
    input logic [BANK_COUNT-1:0]         wb_bus_valid
);

    int acks_in_bank [BANK_COUNT];
    int grants_in_bank [BANK_COUNT];

    // ------------------------------------------------------------
    // per bank counts, bank from the low register bits

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            acks_in_bank[b]   = 0;
            grants_in_bank[b] = 0;
        end
        for (int r = 0; r < RR_COUNT; r++) begin
            if (rd_ack[r]) begin
                acks_in_bank[rd_req_pr[r] % BANK_COUNT]++;
            end
        end
        for (int w = 0; w < WR_COUNT; w++) begin
            if (grant[w]) begin
                grants_in_bank[req_pr[w] % BANK_COUNT]++;
            end
        end
    end

    // no more acks than requests
    ack_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
        $countones(rd_ack) <= $countones(rd_req_valid))
        else $error("read acknowledge count out of bounds");

    // writebacks only for presented writes
    grant_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
        $countones(grant) <= $countones(req_valid))
        else $error("writeback grant count out of bounds");

    // two read ports and one writeback per bank
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        bank_ack_bound: assert property (@(posedge CLK) disable iff (!nRST)
            acks_in_bank[b] <= 2)
            else $error("more than two read acknowledges in one bank");

        bank_grant_bound: assert property (@(posedge CLK) disable iff (!nRST)
            grants_in_bank[b] <= 1)
            else $error("more than one writeback grant in one bank");
    end

    bus_idle_in_reset: assert property (@(posedge CLK)
        !nRST |-> (wb_bus_valid == '0))
        else $error("writeback bus valid during reset");

endmodule

bind prf_top prf_properties #(
    .PR_COUNT   (PR_COUNT),
    .BANK_COUNT (BANK_COUNT),
    .RR_COUNT   (RR_COUNT),
    .WR_COUNT   (WR_COUNT)
) props_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .rd_req_valid (rd_req_valid),
    .rd_req_pr    (rd_req_pr),
    .rd_ack       (rd_ack),
    .req_valid    (req_valid),
    .req_pr       (req_pr),
    .grant        (grant),
    .wb_bus_valid (wb_bus_valid)
);

`default_nettype wire

// ==== test/prf_tb.sv ====
// physical register file testbench
`timescale 1ns/1ns
`default_nettype none

module prf_tb import prf_pkg::*;;

    localparam int PR_COUNT     = DEF_PR_COUNT;
    localparam int BANK_COUNT   = DEF_BANK_COUNT;
    localparam int RR_COUNT     = DEF_RR_COUNT;
    localparam int WR_COUNT     = DEF_WR_COUNT;
    localparam int PR_W         = $clog2(PR_COUNT);
    localparam int ROW_W        = PR_W - $clog2(BANK_COUNT);
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 2000;
    localparam int DRAIN_CYCLES = 32;
    localparam longint WATCHDOG_NS =
        longint'(RESET_CYCLES + PR_COUNT + RUN_CYCLES + DRAIN_CYCLES) * CLK_PERIOD * 2 + 1000;

    // stimulus modes
    localparam int MODE_SWEEP = 0;
    localparam int MODE_RUN   = 1;
    localparam int MODE_DRAIN = 2;

    typedef logic [PR_W-1:0]  pr_t;
    typedef logic [ROW_W-1:0] row_t;
    typedef logic             port_t;

    typedef struct {
        int        wr;
        pr_t       pr;
        prf_word_t data;
    } wb_entry_t;

    logic                                  CLK;
    logic                                  nRST;
    logic      [RR_COUNT-1:0]              rd_req_valid;
    logic      [RR_COUNT-1:0][PR_W-1:0]    rd_req_pr;
    logic      [RR_COUNT-1:0]              rd_ack;
    logic      [RR_COUNT-1:0]              rd_port;
    prf_word_t [BANK_COUNT-1:0][1:0]       rd_data;
    logic      [WR_COUNT-1:0]              wb_valid;
    logic      [WR_COUNT-1:0][PR_W-1:0]    wb_pr;
    prf_word_t [WR_COUNT-1:0]              wb_data;
    logic      [WR_COUNT-1:0]              wb_ready;
    logic      [BANK_COUNT-1:0]            wb_bus_valid;
    logic      [BANK_COUNT-1:0][ROW_W-1:0] wb_bus_upper_pr;
    prf_word_t [BANK_COUNT-1:0]            wb_bus_data;

    // reference model state
    prf_word_t   mirror [PR_COUNT];
    wb_entry_t   pending [$];
    logic        outstanding [WR_COUNT];
    logic        offer_taken [WR_COUNT];
    logic        last_ack [RR_COUNT];
    pr_t         last_pr [RR_COUNT];
    port_t       last_port [RR_COUNT];
    int          reads_checked;
    int          sweep_next;
    logic [15:0] write_serial;
    int          seed;

    prf_top dut_i (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ------------------------------------------------------------
    // failure reporting and compare tasks

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_read(input int r, input prf_word_t actual, input prf_word_t expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("error at %0t ns: read %0d data %h, expected %h",
                $time, r, actual, expected));
        end
    endtask

    task automatic check_bus_entry(input int bank, input row_t row, input prf_word_t data);
        int found;
        found = -1;
        for (int i = 0; i < pending.size(); i++) begin
            if (found < 0 && (pending[i].pr % BANK_COUNT) == bank &&
                (pending[i].pr / BANK_COUNT) == row && pending[i].data == data) begin
                found = i;
            end
        end
        if (found < 0) begin
            stop_with_error($sformatf("error at %0t ns: bank %0d bus row %0d data %h %s",
                $time, bank, row, data, "matches no accepted write"));
        end else begin
            outstanding[pending[found].wr] = 1'b0;
            pending.delete(found);
        end
    endtask

    task automatic check_ack(input int bank, input port_t port, input int actual,
                             input int expected);
        if (actual != expected) begin
            stop_with_error($sformatf("error at %0t ns: bank %0d port %0d has %0d acks, expected %0d",
                $time, bank, port, actual, expected));
        end
    endtask

    task automatic check_ready(input int w, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("error at %0t ns: wb_ready[%0d] is %b, expected %b",
                $time, w, actual, expected));
        end
    endtask

    // ------------------------------------------------------------
    // stimulus, a new request only once the last one was taken

    task automatic drive_reads(input int mode);
        for (int r = 0; r < RR_COUNT; r++) begin
            if (!(rd_req_valid[r] && !last_ack[r])) begin
                rd_req_valid[r] = 1'b0;
                if (mode == MODE_SWEEP && sweep_next < PR_COUNT) begin
                    rd_req_valid[r] = 1'b1;
                    rd_req_pr[r]    = pr_t'(sweep_next);
                    sweep_next++;
                end else if (mode == MODE_RUN && ($random(seed) & 3) != 0) begin
                    rd_req_valid[r] = 1'b1;
                    rd_req_pr[r]    = pr_t'($random(seed));
                end
            end
        end
    endtask

    task automatic drive_writes(input int mode);
        for (int w = 0; w < WR_COUNT; w++) begin
            if (!(wb_valid[w] && !offer_taken[w])) begin
                wb_valid[w] = 1'b0;
                if (mode == MODE_RUN && ($random(seed) & 1) != 0) begin
                    // serial in the upper half keeps every word unique
                    wb_valid[w]  = 1'b1;
                    wb_pr[w]     = pr_t'($random(seed));
                    wb_data[w]   = {write_serial, 16'($random(seed))};
                    write_serial = write_serial + 16'd1;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // model update and checks, sampled at the falling edge

    task automatic check_cycle();
        int  ack_count [BANK_COUNT][2];
        int  req_count [BANK_COUNT];
        int  b;
        pr_t pr;
        // data of last cycle's acks, array already holds last cycle's bus
        for (int r = 0; r < RR_COUNT; r++) begin
            if (last_ack[r]) begin
                pr = last_pr[r];
                check_read(r, rd_data[pr % BANK_COUNT][last_port[r]], mirror[pr]);
                reads_checked++;
            end
        end
        for (int k = 0; k < BANK_COUNT; k++) begin
            if (wb_bus_valid[k]) begin
                check_bus_entry(k, wb_bus_upper_pr[k], wb_bus_data[k]);
                mirror[wb_bus_upper_pr[k] * BANK_COUNT + k] = wb_bus_data[k];
            end
        end
        for (int k = 0; k < BANK_COUNT; k++) begin
            req_count[k]    = 0;
            ack_count[k][0] = 0;
            ack_count[k][1] = 0;
        end
        for (int r = 0; r < RR_COUNT; r++) begin
            b = rd_req_pr[r] % BANK_COUNT;
            if (rd_req_valid[r]) begin
                req_count[b]++;
            end
            if (rd_ack[r] && !rd_req_valid[r]) begin
                stop_with_error($sformatf("error at %0t ns: read %0d acknowledged without a request",
                    $time, r));
            end
            if (rd_ack[r]) begin
                ack_count[b][rd_port[r]]++;
            end
        end
        // port 0 serves any request, port 1 the second one
        for (int k = 0; k < BANK_COUNT; k++) begin
            check_ack(k, 1'b0, ack_count[k][0], (req_count[k] > 0) ? 1 : 0);
            check_ack(k, 1'b1, ack_count[k][1], (req_count[k] > 1) ? 1 : 0);
        end
        for (int w = 0; w < WR_COUNT; w++) begin
            check_ready(w, wb_ready[w], !(outstanding[w] && wb_valid[w]));
            offer_taken[w] = wb_valid[w] && wb_ready[w];
            if (offer_taken[w]) begin
                pending.push_back('{wr: w, pr: wb_pr[w], data: wb_data[w]});
                outstanding[w] = 1'b1;
            end
        end
        for (int r = 0; r < RR_COUNT; r++) begin
            last_ack[r]  = rd_ack[r];
            last_pr[r]   = rd_req_pr[r];
            last_port[r] = rd_port[r];
        end
    endtask

    task automatic run_cycle(input int mode);
        @(posedge CLK);
        #DRIVE_DELAY;
        drive_reads(mode);
        drive_writes(mode);
        @(negedge CLK);
        check_cycle();
    endtask

    // ------------------------------------------------------------
    // main sequence

    initial begin
        seed          = 32'h0b170e74;
        CLK           = 1'b0;
        nRST          = 1'b1;
        rd_req_valid  = '0;
        rd_req_pr     = '0;
        wb_valid      = '0;
        wb_pr         = '0;
        wb_data       = '0;
        reads_checked = 0;
        sweep_next    = 0;
        write_serial  = '0;
        for (int i = 0; i < PR_COUNT; i++) begin
            mirror[i] = '0;
        end
        for (int w = 0; w < WR_COUNT; w++) begin
            outstanding[w] = 1'b0;
            offer_taken[w] = 1'b0;
        end
        for (int r = 0; r < RR_COUNT; r++) begin
            last_ack[r]  = 1'b0;
            last_pr[r]   = '0;
            last_port[r] = 1'b0;
        end
        #5;
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        nRST = 1'b1;
        // every register once, no writes yet so all read as zero
        while (reads_checked < PR_COUNT) begin
            run_cycle(MODE_SWEEP);
        end
        repeat (RUN_CYCLES) run_cycle(MODE_RUN);
        repeat (DRAIN_CYCLES) run_cycle(MODE_DRAIN);
        if (pending.size() != 0) begin
            stop_with_error($sformatf("%0d accepted writes never appeared on the writeback bus",
                pending.size()));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_error($sformatf("timeout, the run did not end within %0d ns", WATCHDOG_NS));
    end

endmodule

`default_nettype wire

// ==== prf_top.f ====
verilog/prf_pkg.sv
verilog/bank_arbiter.sv
verilog/wb_hold.sv
verilog/read_port_select.sv
verilog/wb_select.sv
verilog/reg_bank_array.sv
verilog/prf_top.sv
test/prf_properties.sv
test/prf_tb.sv

// ==== Makefile ====
# Verilator build and run of the physical register file testbench

SIM      := verilator
TOP      := prf_tb
FILELIST := prf_top.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal -Mdir $(BUILD)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
